// File: src/gcm_params.svh
// ====================
// Widths and constants shared by the GCM tag datapath
// Text length must be a whole number of 128-bit blocks
// Block counter width limits a message to 65535 blocks
// ====================
`ifndef GCM_PARAMS_SVH
`define GCM_PARAMS_SVH

// Block and IV widths
`define GCM_BLOCK_BITS 128
`define GCM_IV_BITS 96

// Bit count to block count
`define GCM_BLOCK_SHIFT 7
`define GCM_COUNT_BITS 16

// J0 counter seed and top byte of the reduction constant
`define GCM_J0_TAIL 1
`define GCM_R_POLY 8'he1

`endif

// File: src/gcm_pkg.sv
// ====================
// Types shared by the GCM tag datapath
// Session fields are locked once per message
// ====================
`include "gcm_params.svh"

package gcm_pkg;

    // Per-message parameters, sampled at an accepted start
    typedef struct packed {
        logic                        decrypt;
        logic [`GCM_IV_BITS-1:0]     iv;
        logic [`GCM_BLOCK_BITS-1:0]  aad;
        logic [63:0]                 length_aad;
        logic [63:0]                 length_text;
        logic [`GCM_BLOCK_BITS-1:0]  hash_subkey;
        logic [`GCM_BLOCK_BITS-1:0]  ek_j0;
        logic [`GCM_BLOCK_BITS-1:0]  expected_tag;
    } gcm_session_t;

    // Length block layout, len(A) in the upper half
    typedef struct packed {
        logic [63:0] aad_bits;
        logic [63:0] text_bits;
    } ghash_lengths_t;

    // One GHASH input word, raw or as the length block
    typedef union packed {
        logic [`GCM_BLOCK_BITS-1:0] raw;
        ghash_lengths_t             lengths;
    } ghash_block_u;

    // Request to the multiplier
    // first drops the old state instead of folding it in
    typedef struct packed {
        logic [`GCM_BLOCK_BITS-1:0] block;
        logic                       first;
    } ghash_req_t;

endpackage

// File: src/gcm_iv_counter.sv
// ====================
// Counter block source for the text stream
// Only the standard inc32 is supported, wrapping mod 2^32
// Start and beat never coincide, start wins if they do
// ====================
`include "gcm_params.svh"

module gcm_iv_counter
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic [`GCM_IV_BITS-1:0]     i_iv,
    input  logic                        i_beat,
    output logic [`GCM_BLOCK_BITS-1:0]  o_counter_block
);

    localparam int CTR_BITS = `GCM_BLOCK_BITS - `GCM_IV_BITS;

    // First text block uses inc32(J0)
    localparam logic [CTR_BITS-1:0] CTR_SEED = CTR_BITS'(`GCM_J0_TAIL + 1);

    logic [`GCM_IV_BITS-1:0] iv_q;
    logic [CTR_BITS-1:0]     ctr_q;

    // IV held for the whole message
    always_ff @(posedge i_clock)
    begin
        if (i_start)
            iv_q <= i_iv;
    end

    // 32-bit counter, one step per accepted beat
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            ctr_q <= '0;
        else if (i_start)
            ctr_q <= CTR_SEED;
        else if (i_beat)
            ctr_q <= ctr_q + 1'b1;
    end

    assign o_counter_block = {iv_q, ctr_q};

endmodule

// File: src/gcm_ghash_sequencer.sv
// ====================
// Message FSM, feeds AAD, text and length blocks to GHASH
// Exactly one AAD block per message
// A start while busy is dropped and reported on o_fault_start
// ====================
`include "gcm_params.svh"

module gcm_ghash_sequencer
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  gcm_pkg::gcm_session_t       i_session,
    input  logic                        i_text_valid,
    input  logic [`GCM_BLOCK_BITS-1:0]  i_text,
    input  logic                        i_mac_busy,
    output logic                        o_text_ready,
    output logic                        o_busy,
    output logic                        o_req_valid,
    output gcm_pkg::ghash_req_t         o_req,
    output logic                        o_ghash_done,
    output gcm_pkg::gcm_session_t       o_session,
    output logic                        o_fault_start
);

    // State encodings
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_AAD    = 3'd1;
    localparam logic [2:0] ST_TEXT   = 3'd2;
    localparam logic [2:0] ST_LENGTH = 3'd3;
    localparam logic [2:0] ST_WAIT   = 3'd4;

    logic [2:0]                  state;
    logic [`GCM_COUNT_BITS-1:0]  blocks_left;
    gcm_pkg::ghash_block_u       len_word;

    // ====================
    // Phase control
    // ====================
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state       <= ST_IDLE;
            blocks_left <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (i_start)
                    begin
                        state       <= ST_AAD;
                        blocks_left <= i_session.length_text[`GCM_BLOCK_SHIFT +: `GCM_COUNT_BITS];
                    end
                // Empty text goes straight to the length block
                ST_AAD:
                    if (!i_mac_busy)
                        state <= (blocks_left == '0) ? ST_LENGTH : ST_TEXT;
                ST_TEXT:
                    if (o_req_valid)
                    begin
                        blocks_left <= blocks_left - 1'b1;
                        if (blocks_left == 1)
                            state <= ST_LENGTH;
                    end
                ST_LENGTH:
                    if (!i_mac_busy)
                        state <= ST_WAIT;
                // Multiplier idle again means the length block is folded in
                ST_WAIT:
                    if (!i_mac_busy)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Session locked at an accepted start
    always_ff @(posedge i_clock)
    begin
        if (state == ST_IDLE && i_start)
            o_session <= i_session;
    end

    // Length block, len(A) || len(C)
    always_comb
    begin
        len_word.lengths.aad_bits  = o_session.length_aad;
        len_word.lengths.text_bits = o_session.length_text;
    end

    // ====================
    // Requests to the multiplier
    // ====================
    always_comb
    begin
        o_req.first = 1'b0;
        o_req.block = i_text;
        o_req_valid = 1'b0;
        case (state)
            ST_AAD:
            begin
                o_req.first = 1'b1;
                o_req.block = o_session.aad;
                o_req_valid = !i_mac_busy;
            end
            ST_TEXT:
                o_req_valid = i_text_valid && !i_mac_busy;
            ST_LENGTH:
            begin
                o_req.block = len_word.raw;
                o_req_valid = !i_mac_busy;
            end
            default:
                o_req_valid = 1'b0;
        endcase
    end

    assign o_text_ready  = (state == ST_TEXT) && !i_mac_busy;
    assign o_busy        = (state != ST_IDLE);
    assign o_ghash_done  = (state == ST_WAIT) && !i_mac_busy;
    assign o_fault_start = i_start && (state != ST_IDLE);

endmodule

// File: src/ghash_mac.sv
// ====================
// Bit-serial GHASH multiply-accumulate, Y = (X ^ Y) * H
// 129 cycles per block, requests taken only while idle
// o_y stays valid from o_done until the next block ends
// ====================
`include "gcm_params.svh"

module ghash_mac
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_req_valid,
    input  gcm_pkg::ghash_req_t         i_req,
    input  logic [`GCM_BLOCK_BITS-1:0]  i_hash_subkey,
    output logic                        o_busy,
    output logic                        o_done,
    output logic [`GCM_BLOCK_BITS-1:0]  o_y
);

    localparam int STEP_BITS = $clog2(`GCM_BLOCK_BITS + 1);
    localparam logic [STEP_BITS-1:0] LAST_STEP = STEP_BITS'(`GCM_BLOCK_BITS);

    // R = 11100001 || 0^120
    localparam logic [`GCM_BLOCK_BITS-1:0] R_CONST =
        {`GCM_R_POLY, {(`GCM_BLOCK_BITS - 8){1'b0}}};

    logic [STEP_BITS-1:0]       step;
    logic [`GCM_BLOCK_BITS-1:0] x_q;
    logic [`GCM_BLOCK_BITS-1:0] v_q;
    logic [`GCM_BLOCK_BITS-1:0] z_q;

    // ====================
    // Step counter
    // ====================
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_busy <= 1'b0;
            o_done <= 1'b0;
            step   <= '0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!o_busy)
            begin
                if (i_req_valid)
                begin
                    o_busy <= 1'b1;
                    step   <= '0;
                end
            end
            // Extra step writes the result back
            else if (step == LAST_STEP)
            begin
                o_busy <= 1'b0;
                o_done <= 1'b1;
            end
            else
                step <= step + 1'b1;
        end
    end

    // ====================
    // Multiply, MSB of X first
    // ====================
    always_ff @(posedge i_clock)
    begin
        if (!o_busy && i_req_valid)
        begin
            x_q <= i_req.first ? i_req.block : (i_req.block ^ o_y);
            v_q <= i_hash_subkey;
            z_q <= '0;
        end
        else if (o_busy && step != LAST_STEP)
        begin
            z_q <= x_q[`GCM_BLOCK_BITS-1] ? (z_q ^ v_q) : z_q;
            x_q <= x_q << 1;
            // Right shift of V, reduce when bit 127 falls out
            v_q <= (v_q >> 1) ^ (v_q[0] ? R_CONST : '0);
        end
        else if (o_busy)
            o_y <= z_q;
    end

endmodule

// File: src/gcm_tag_check.sv
// ====================
// Tag = E(K, J0) ^ GHASH, registered one cycle after ghash_done
// Fail only in decrypt mode, cleared by the next accepted start
// Fault is sticky until i_clear_fault, a new fault wins
// ====================
`include "gcm_params.svh"

module gcm_tag_check
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_ghash_done,
    input  logic [`GCM_BLOCK_BITS-1:0]  i_y,
    input  gcm_pkg::gcm_session_t       i_session,
    input  logic                        i_start_accepted,
    input  logic                        i_fault_start,
    input  logic                        i_clear_fault,
    output logic [`GCM_BLOCK_BITS-1:0]  o_tag,
    output logic                        o_tag_valid,
    output logic                        o_fail,
    output logic                        o_fault
);

    logic [`GCM_BLOCK_BITS-1:0] tag_next;

    assign tag_next = i_session.ek_j0 ^ i_y;

    // Tag holds until the next message completes
    always_ff @(posedge i_clock)
    begin
        if (i_ghash_done)
            o_tag <= tag_next;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_tag_valid <= 1'b0;
            o_fail      <= 1'b0;
            o_fault     <= 1'b0;
        end
        else
        begin
            o_tag_valid <= i_ghash_done;
            // Compare against the expected tag, decrypt only
            if (i_start_accepted)
                o_fail <= 1'b0;
            else if (i_ghash_done)
                o_fail <= i_session.decrypt && (tag_next != i_session.expected_tag);
            // Start while busy
            if (i_fault_start)
                o_fault <= 1'b1;
            else if (i_clear_fault)
                o_fault <= 1'b0;
        end
    end

endmodule

// File: src/gcm_tag_top.sv
// ====================
// GCM authentication back end, one block per beat
// H and E(K, J0) come from an external cipher in i_session
// i_text is always ciphertext
// ====================
`include "gcm_params.svh"

module gcm_tag_top
(
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  gcm_pkg::gcm_session_t       i_session,
    input  logic                        i_text_valid,
    input  logic [`GCM_BLOCK_BITS-1:0]  i_text,
    input  logic                        i_clear_fault,
    output logic                        o_text_ready,
    output logic                        o_busy,
    output logic [`GCM_BLOCK_BITS-1:0]  o_counter_block,
    output logic [`GCM_BLOCK_BITS-1:0]  o_tag,
    output logic                        o_tag_valid,
    output logic                        o_fail,
    output logic                        o_fault
);

    // Handshake strobes
    logic start_accepted;
    logic beat;

    // Sequencer to multiplier
    logic                       req_valid;
    gcm_pkg::ghash_req_t        req;
    logic                       mac_busy;
    logic [`GCM_BLOCK_BITS-1:0] y;

    // Sequencer to tag check
    gcm_pkg::gcm_session_t session;
    logic                  ghash_done;
    logic                  fault_start;

    assign start_accepted = i_start && !o_busy;
    assign beat           = i_text_valid && o_text_ready;

    gcm_iv_counter u_iv_counter
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_start         (start_accepted),
        .i_iv            (i_session.iv),
        .i_beat          (beat),
        .o_counter_block (o_counter_block)
    );

    gcm_ghash_sequencer u_sequencer
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_session     (i_session),
        .i_text_valid  (i_text_valid),
        .i_text        (i_text),
        .i_mac_busy    (mac_busy),
        .o_text_ready  (o_text_ready),
        .o_busy        (o_busy),
        .o_req_valid   (req_valid),
        .o_req         (req),
        .o_ghash_done  (ghash_done),
        .o_session     (session),
        .o_fault_start (fault_start)
    );

    // Sequencer tracks completion through mac_busy
    ghash_mac u_mac
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_req_valid   (req_valid),
        .i_req         (req),
        .i_hash_subkey (session.hash_subkey),
        .o_busy        (mac_busy),
        .o_done        (),
        .o_y           (y)
    );

    gcm_tag_check u_tag_check
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_ghash_done     (ghash_done),
        .i_y              (y),
        .i_session        (session),
        .i_start_accepted (start_accepted),
        .i_fault_start    (fault_start),
        .i_clear_fault    (i_clear_fault),
        .o_tag            (o_tag),
        .o_tag_valid      (o_tag_valid),
        .o_fail           (o_fail),
        .o_fault          (o_fault)
    );

endmodule

// File: bench/gcm_tag_props.sv
// ====================
// Handshake and pulse checks, bound to gcm_tag_top
// Reset values are checked one cycle after reset is seen
// ====================

module gcm_tag_props
(
    input logic i_clock,
    input logic i_reset,
    input logic o_busy,
    input logic o_text_ready,
    input logic o_tag_valid,
    input logic o_fail,
    input logic o_fault
);

    timeunit 1ns;
    timeprecision 100ps;

    // Tag strobe is a single-cycle pulse
    tag_valid_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        o_tag_valid |=> !o_tag_valid)
        else $error("o_tag_valid stayed high for more than one cycle");

    // Text is only taken inside a message
    ready_needs_busy: assert property (@(posedge i_clock) disable iff (i_reset)
        !o_busy |-> !o_text_ready)
        else $error("o_text_ready high while o_busy is low");

    // Control outputs quiet under reset
    reset_quiet: assert property (@(posedge i_clock)
        i_reset |=> !(o_busy || o_text_ready || o_tag_valid || o_fail || o_fault))
        else $error("control output high during reset");

endmodule

bind gcm_tag_top gcm_tag_props u_props
(
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .o_busy       (o_busy),
    .o_text_ready (o_text_ready),
    .o_tag_valid  (o_tag_valid),
    .o_fail       (o_fail),
    .o_fault      (o_fault)
);

// File: bench/gcm_tag_tb.sv
// ====================
// Testbench for the GCM tag back end
// Every message has one AAD block and whole text blocks
// Expected tags come from a software GHASH model
// Random sessions and text, fixed seed
// ====================
`include "gcm_params.svh"

module gcm_tag_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h43e2_c221;

    // Text blocks per message
    localparam int N_ENC   = 3;
    localparam int N_DEC   = 2;
    localparam int N_STALL = 4;

    // AAD and length block on top of the text, decrypt message runs twice
    localparam int TOTAL_BLOCKS = (N_ENC + 2) + 2 * (N_DEC + 2) + 2 + (N_STALL + 2);
    localparam int WATCHDOG_CYCLES = TOTAL_BLOCKS * 140 + 200;

    // DUT ports
    logic                        i_clock;
    logic                        i_reset;
    logic                        i_start;
    gcm_pkg::gcm_session_t       i_session;
    logic                        i_text_valid;
    logic [`GCM_BLOCK_BITS-1:0]  i_text;
    logic                        i_clear_fault;
    logic                        o_text_ready;
    logic                        o_busy;
    logic [`GCM_BLOCK_BITS-1:0]  o_counter_block;
    logic [`GCM_BLOCK_BITS-1:0]  o_tag;
    logic                        o_tag_valid;
    logic                        o_fail;
    logic                        o_fault;

    // Current message and its expected result
    gcm_pkg::gcm_session_t       session;
    logic [`GCM_BLOCK_BITS-1:0]  text_blocks[$];
    logic [`GCM_BLOCK_BITS-1:0]  exp_tag;
    logic                        exp_fail;
    int                          tags_seen = 0;
    int                          errors = 0;
    bit                          run_done = 1'b0;

    gcm_tag_top uut
    (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_start         (i_start),
        .i_session       (i_session),
        .i_text_valid    (i_text_valid),
        .i_text          (i_text),
        .i_clear_fault   (i_clear_fault),
        .o_text_ready    (o_text_ready),
        .o_busy          (o_busy),
        .o_counter_block (o_counter_block),
        .o_tag           (o_tag),
        .o_tag_valid     (o_tag_valid),
        .o_fail          (o_fail),
        .o_fault         (o_fault)
    );

    always #10 i_clock = ~i_clock;

    // ====================
    // Reference model
    // ====================

    // GF(2^128) multiply, bit 0 of the spec is the MSB here
    function automatic logic [127:0] gf_mult(input logic [127:0] x, input logic [127:0] y);
        logic [127:0] z;
        logic [127:0] v;
        int           i;
        z = '0;
        v = y;
        for (i = 0; i < 128; i++)
        begin
            if (x[127 - i])
                z = z ^ v;
            if (v[0])
                v = (v >> 1) ^ {`GCM_R_POLY, 120'b0};
            else
                v = v >> 1;
        end
        return z;
    endfunction

    // GHASH over AAD, text and len(A) || len(C), then XOR with E(K, J0)
    function automatic logic [127:0] reference_tag(input gcm_pkg::gcm_session_t s);
        logic [127:0] y;
        y = gf_mult(s.aad, s.hash_subkey);
        foreach (text_blocks[i])
            y = gf_mult(y ^ text_blocks[i], s.hash_subkey);
        y = gf_mult(y ^ {s.length_aad, s.length_text}, s.hash_subkey);
        return s.ek_j0 ^ y;
    endfunction

    // IV || inc32(J0) advanced once per earlier beat
    function automatic logic [127:0] expected_counter(input logic [95:0] iv, input int index);
        return {iv, 32'(`GCM_J0_TAIL + 1 + index)};
    endfunction

    function automatic logic [127:0] random_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // ====================
    // Checks
    // ====================
    task automatic check_equal(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // Tag and fail flag compared on every tag strobe
    always @(posedge i_clock)
    begin
        if (!i_reset && o_tag_valid)
        begin
            check_equal("o_tag", o_tag, exp_tag);
            check_equal("o_fail", 128'(o_fail), 128'(exp_fail));
            tags_seen = tags_seen + 1;
        end
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        errors++;
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $fatal(1);
    end

    // Run stopped by something other than the testbench itself
    final
    begin
        if (!run_done && errors == 0)
            $display("Finished with errors");
    end

    // ====================
    // Stimulus
    // ====================
    task automatic new_message(input bit decrypt, input int n_text);
        session.decrypt      = decrypt;
        session.iv           = {$urandom(), $urandom(), $urandom()};
        session.aad          = random_block();
        session.length_aad   = 64'(`GCM_BLOCK_BITS);
        session.length_text  = 64'(n_text) << `GCM_BLOCK_SHIFT;
        session.hash_subkey  = random_block();
        session.ek_j0        = random_block();
        session.expected_tag = random_block();
        text_blocks.delete();
        for (int i = 0; i < n_text; i++)
            text_blocks.push_back(random_block());
        if (decrypt)
            session.expected_tag = reference_tag(session);
    endtask

    task automatic start_message(input gcm_pkg::gcm_session_t s);
        check_equal("o_busy", 128'(o_busy), 128'(0));
        i_session = s;
        i_start   = 1'b1;
        @(posedge i_clock);
        #1;
        i_start = 1'b0;
        // Accepted start clears the previous fail
        check_equal("o_fail", 128'(o_fail), 128'(0));
    endtask

    // One text beat, counter block checked on the accepting edge
    task automatic send_block(input logic [127:0] blk, input int index, input bit stall);
        int gap;
        if (stall)
        begin
            do @(posedge i_clock); while (!o_text_ready);
            gap = $urandom_range(1, 6);
            repeat (gap) @(posedge i_clock);
            #1;
        end
        i_text       = blk;
        i_text_valid = 1'b1;
        do @(posedge i_clock); while (!o_text_ready);
        check_equal("o_counter_block", o_counter_block, expected_counter(session.iv, index));
        #1;
        i_text_valid = 1'b0;
    endtask

    task automatic run_message(input bit stall, input bit busy_start, input bit fail_expected);
        int seen;
        exp_tag  = reference_tag(session);
        exp_fail = fail_expected;
        seen     = tags_seen;
        start_message(session);
        // Decoy start with another session, must be ignored
        if (busy_start)
        begin
            check_equal("o_busy", 128'(o_busy), 128'(1));
            i_session    = session;
            i_session.iv = ~session.iv;
            i_start      = 1'b1;
            @(posedge i_clock);
            #1;
            i_start = 1'b0;
            check_equal("o_fault", 128'(o_fault), 128'(1));
        end
        foreach (text_blocks[i])
            send_block(text_blocks[i], i, stall);
        do @(posedge i_clock); while (!o_tag_valid);
        #1;
        check_equal("tags_seen", 128'(tags_seen), 128'(seen + 1));
        if (busy_start)
        begin
            // Still set from the decoy start
            check_equal("o_fault", 128'(o_fault), 128'(1));
            i_clear_fault = 1'b1;
            @(posedge i_clock);
            #1;
            i_clear_fault = 1'b0;
            check_equal("o_fault", 128'(o_fault), 128'(0));
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        i_clock       = 1'b0;
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_session     = '0;
        i_text_valid  = 1'b0;
        i_text        = '0;
        i_clear_fault = 1'b0;
        repeat (8) @(posedge i_clock);
        #1;
        i_reset = 1'b0;

        // Outputs idle after reset
        check_equal("o_busy", 128'(o_busy), 128'(0));
        check_equal("o_text_ready", 128'(o_text_ready), 128'(0));
        check_equal("o_tag_valid", 128'(o_tag_valid), 128'(0));
        check_equal("o_fail", 128'(o_fail), 128'(0));
        check_equal("o_fault", 128'(o_fault), 128'(0));

        // Encrypt, three blocks
        new_message(1'b0, N_ENC);
        run_message(1'b0, 1'b0, 1'b0);

        // Decrypt, good tag then one flipped bit
        new_message(1'b1, N_DEC);
        run_message(1'b0, 1'b0, 1'b0);
        session.expected_tag = session.expected_tag ^ (128'(1) << $urandom_range(0, 127));
        run_message(1'b0, 1'b0, 1'b1);

        // No text at all
        new_message(1'b0, 0);
        run_message(1'b0, 1'b0, 1'b0);

        // Stalled text stream plus a start while busy
        new_message(1'b1, N_STALL);
        run_message(1'b1, 1'b1, 1'b0);

        run_done = 1'b1;
        if (errors == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

// File: gcm_tag.f
+incdir+src
src/gcm_pkg.sv
src/gcm_iv_counter.sv
src/gcm_ghash_sequencer.sv
src/ghash_mac.sv
src/gcm_tag_check.sv
src/gcm_tag_top.sv
bench/gcm_tag_props.sv
bench/gcm_tag_tb.sv

// File: run.sh
#!/bin/sh
# Build the GCM tag testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f gcm_tag.f --top-module gcm_tag_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vgcm_tag_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
